// File: hdl/soc_ic_macros.svh
`ifndef SOC_IC_MACROS_SVH
`define SOC_IC_MACROS_SVH

// Bus widths of the TCDM master ports
`define SOC_IC_ADDR_W 32
`define SOC_IC_DATA_W 32
`define SOC_IC_BE_W   (`SOC_IC_DATA_W / 8)  // One enable per byte lane

// Packed request: master, region, wen, address, wdata, be
`define SOC_IC_REQ_W (1 + 2 + 1 + `SOC_IC_ADDR_W + `SOC_IC_DATA_W + `SOC_IC_BE_W)

// Request FIFO between arbiter and memory
`define SOC_IC_FIFO_DEPTH 4

// Memory geometry
`define SOC_IC_NR_L2_BANKS 4    // Word interleaved
`define SOC_IC_BANK_WORDS  64   // Per interleaved bank
`define SOC_IC_PRIV_WORDS  128  // Contiguous private bank

// Address map, inclusive bounds
`define SOC_IC_PRIV_START 32'h1C00_0000
`define SOC_IC_PRIV_END   32'h1C00_01FF
`define SOC_IC_L2_START   32'h1C01_0000
`define SOC_IC_L2_END     32'h1C01_03FF

// Legacy alias of the fabric-controller data port
`define SOC_IC_ALIAS_W    12      // Width of the remapped prefix
`define SOC_IC_ALIAS_FROM 12'h000
`define SOC_IC_ALIAS_TO   12'h1C0

// Read data for accesses outside every region
`define SOC_IC_ERR_RDATA 32'hBADC_AB1E

`endif

// File: hdl/soc_ic_pkg.sv
`default_nettype none

`include "soc_ic_macros.svh"

package soc_ic_pkg;

    ////////////////////////////////////////
    // Bus field types
    ////////////////////////////////////////

    typedef logic [`SOC_IC_ADDR_W-1:0] addr_t;  // Byte address
    typedef logic [`SOC_IC_DATA_W-1:0] data_t;  // Data word
    typedef logic [`SOC_IC_BE_W-1:0]   be_t;    // Byte enables

    // Indexing inside the memory
    typedef logic [$clog2(`SOC_IC_NR_L2_BANKS)-1:0] bank_sel_t;  // Interleaved bank
    typedef logic [$clog2(`SOC_IC_PRIV_WORDS)-1:0]  word_idx_t;  // Word inside a bank

    ////////////////////////////////////////
    // Decode and routing
    ////////////////////////////////////////

    // Target of a request after the L2 demux rules
    typedef enum logic [1:0] {
        REGION_L2   = 2'd0,  // Interleaved banks
        REGION_PRIV = 2'd1,  // Private bank
        REGION_NONE = 2'd2   // Unmapped, answered with an error
    } region_e;

    // Issuing master, carried with the request for response routing
    typedef enum logic {
        MST_FC   = 1'b0,  // Fabric-controller data port
        MST_UDMA = 1'b1   // uDMA channel
    } master_e;

    // One queued request
    // MSB first: master, region, wen, address, wdata, be
    typedef logic [`SOC_IC_REQ_W-1:0] req_t;

endpackage

`default_nettype wire

// File: hdl/tcdm_master_arbiter.sv
`default_nettype none

`include "soc_ic_macros.svh"

module tcdm_master_arbiter (
    input  logic              clk_i,
    input  logic              reset_i,
    // Fabric-controller data port
    input  logic              fc_req_i,
    input  logic              fc_wen_i,      // 1 read, 0 write
    input  soc_ic_pkg::addr_t fc_add_i,
    input  soc_ic_pkg::data_t fc_wdata_i,
    input  soc_ic_pkg::be_t   fc_be_i,
    output logic              fc_gnt_o,
    // uDMA channel
    input  logic              udma_req_i,
    input  logic              udma_wen_i,
    input  soc_ic_pkg::addr_t udma_add_i,
    input  soc_ic_pkg::data_t udma_wdata_i,
    input  soc_ic_pkg::be_t   udma_be_i,
    output logic              udma_gnt_o,
    // Request FIFO write side
    input  logic              fifo_full_i,
    output logic              push_o,
    output soc_ic_pkg::req_t  push_data_o
);
    import soc_ic_pkg::*;

    addr_t   fc_add_remap;  // FC address after the alias
    master_e last_q;        // Master granted most recently
    master_e win_mst;
    logic    win_wen;
    addr_t   win_add;
    data_t   win_wdata;
    be_t     win_be;
    region_e win_region;

    // L2 demux rules, anything outside both windows is unmapped
    function automatic region_e decode_region(input addr_t add);
        region_e region;
        region = REGION_NONE;
        if (add >= `SOC_IC_L2_START && add <= `SOC_IC_L2_END) begin
            region = REGION_L2;
        end else if (add >= `SOC_IC_PRIV_START && add <= `SOC_IC_PRIV_END) begin
            region = REGION_PRIV;
        end
        return region;
    endfunction

    ////////////////////////////////////////
    // Legacy FC alias
    ////////////////////////////////////////

    // Prefix 0x000 reaches the 0x1C0 block, uDMA addresses pass untouched
    always_comb begin
        fc_add_remap = fc_add_i;
        if (fc_add_i[`SOC_IC_ADDR_W-1 -: `SOC_IC_ALIAS_W] == `SOC_IC_ALIAS_FROM) begin
            fc_add_remap[`SOC_IC_ADDR_W-1 -: `SOC_IC_ALIAS_W] = `SOC_IC_ALIAS_TO;
        end
    end

    ////////////////////////////////////////
    // Round-robin grant
    ////////////////////////////////////////

    always_comb begin
        fc_gnt_o   = 1'b0;
        udma_gnt_o = 1'b0;
        if (!fifo_full_i) begin                     // No room, no grant
            if (fc_req_i && udma_req_i) begin
                fc_gnt_o   = (last_q == MST_UDMA);  // Loser of last round wins
                udma_gnt_o = (last_q == MST_FC);
            end else begin
                fc_gnt_o   = fc_req_i;
                udma_gnt_o = udma_req_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            last_q <= MST_UDMA;  // FC goes first after reset
        end else if (push_o) begin
            last_q <= win_mst;
        end
    end

    // Winner mux
    assign win_mst    = udma_gnt_o ? MST_UDMA : MST_FC;
    assign win_wen    = udma_gnt_o ? udma_wen_i : fc_wen_i;
    assign win_add    = udma_gnt_o ? udma_add_i : fc_add_remap;
    assign win_wdata  = udma_gnt_o ? udma_wdata_i : fc_wdata_i;
    assign win_be     = udma_gnt_o ? udma_be_i : fc_be_i;
    assign win_region = decode_region(win_add);

    // One push per grant
    assign push_o      = fc_gnt_o | udma_gnt_o;
    assign push_data_o = {win_mst, win_region, win_wen, win_add, win_wdata, win_be};

endmodule

`default_nettype wire

// File: hdl/req_fifo.sv
`default_nettype none

`include "soc_ic_macros.svh"

module req_fifo (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             push_i,
    input  logic             pop_i,
    input  soc_ic_pkg::req_t push_data_i,
    output logic             full_o,
    output logic             empty_o,
    output soc_ic_pkg::req_t head_o
);
    import soc_ic_pkg::*;

    localparam int unsigned DEPTH = `SOC_IC_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    req_t             mem_q [DEPTH];  // Entry storage
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;        // Occupancy
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;   // Overflow ignored
    assign do_pop  = pop_i && !empty_o;   // Underflow ignored

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign head_o  = mem_q[rd_ptr_q];     // Read combinationally by the memory

    // Pointers and count
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Idle or push with pop
            endcase
        end
    end

    // Storage, entry visible at the head one cycle after the push
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/l2_memory.sv
`default_nettype none

`include "soc_ic_macros.svh"

module l2_memory (
    input  logic              clk_i,
    input  logic              reset_i,
    // Request FIFO read side
    input  logic              empty_i,
    input  soc_ic_pkg::req_t  head_i,
    output logic              pop_o,
    // Fabric-controller response
    output logic              fc_r_valid_o,
    output logic              fc_r_opc_o,    // 1 on error
    output soc_ic_pkg::data_t fc_r_rdata_o,
    // uDMA response
    output logic              udma_r_valid_o,
    output logic              udma_r_opc_o,
    output soc_ic_pkg::data_t udma_r_rdata_o
);
    import soc_ic_pkg::*;

    localparam int unsigned NR_BANKS   = `SOC_IC_NR_L2_BANKS;
    localparam int unsigned BANK_WORDS = `SOC_IC_BANK_WORDS;
    localparam int unsigned PRIV_WORDS = `SOC_IC_PRIV_WORDS;
    localparam int unsigned L2_IDX_W   = $clog2(BANK_WORDS);

    data_t l2_bank_q [NR_BANKS][BANK_WORDS];  // Interleaved region
    data_t priv_q [PRIV_WORDS];               // Private region

    // Head entry fields
    logic       h_mst;
    logic [1:0] h_region;
    logic       h_wen;
    addr_t      h_addr;
    data_t      h_wdata;
    be_t        h_be;

    bank_sel_t           bank_sel;
    logic [L2_IDX_W-1:0] l2_word;   // Word inside an interleaved bank
    word_idx_t           priv_word;
    data_t               rd_data;
    logic                rd_err;

    // Response register
    logic    rsp_valid_q;
    master_e rsp_mst_q;
    logic    rsp_opc_q;
    data_t   rsp_rdata_q;

    // Byte-lane merge for partial writes
    function automatic data_t merge_be(input data_t old_w, input data_t new_w, input be_t be);
        data_t res;
        res = old_w;
        for (int b = 0; b < `SOC_IC_BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign {h_mst, h_region, h_wen, h_addr, h_wdata, h_be} = head_i;

    assign pop_o = !empty_i;  // Never stalls, one request per cycle

    // Word interleaving across banks, private region is flat
    assign bank_sel  = h_addr[3:2];
    assign l2_word   = h_addr[9:4];
    assign priv_word = h_addr[8:2];

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    always_comb begin
        rd_data = '0;     // Writes answer with zero
        rd_err  = 1'b0;
        case (h_region)
            REGION_L2: begin
                if (h_wen) rd_data = l2_bank_q[bank_sel][l2_word];
            end
            REGION_PRIV: begin
                if (h_wen) rd_data = priv_q[priv_word];
            end
            default: begin
                rd_err = 1'b1;
                if (h_wen) rd_data = `SOC_IC_ERR_RDATA;
            end
        endcase
    end

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin                 // Contents start at zero
            for (int b = 0; b < NR_BANKS; b++) begin
                for (int w = 0; w < BANK_WORDS; w++) begin
                    l2_bank_q[b][w] <= '0;
                end
            end
            for (int w = 0; w < PRIV_WORDS; w++) begin
                priv_q[w] <= '0;
            end
        end else if (pop_o && !h_wen) begin
            if (h_region == REGION_L2) begin
                l2_bank_q[bank_sel][l2_word] <=
                    merge_be(l2_bank_q[bank_sel][l2_word], h_wdata, h_be);
            end else if (h_region == REGION_PRIV) begin
                priv_q[priv_word] <= merge_be(priv_q[priv_word], h_wdata, h_be);
            end
            // Unmapped writes are dropped
        end
    end

    // Response one cycle after the pop
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            rsp_mst_q   <= master_e'(h_mst);  // Issuer recorded by the arbiter
            rsp_opc_q   <= rd_err;
            rsp_rdata_q <= rd_data;
        end
    end

    // Steer the valid strobe, data and opc are shared
    assign fc_r_valid_o   = rsp_valid_q && (rsp_mst_q == MST_FC);
    assign udma_r_valid_o = rsp_valid_q && (rsp_mst_q == MST_UDMA);
    assign fc_r_opc_o     = rsp_opc_q;
    assign udma_r_opc_o   = rsp_opc_q;
    assign fc_r_rdata_o   = rsp_rdata_q;
    assign udma_r_rdata_o = rsp_rdata_q;

endmodule

`default_nettype wire

// File: hdl/soc_interconnect_top.sv
`default_nettype none

module soc_interconnect_top (
    input  logic              clk_i,
    input  logic              reset_i,
    // Fabric-controller data port
    input  logic              fc_req_i,
    input  soc_ic_pkg::addr_t fc_add_i,
    input  logic              fc_wen_i,
    input  soc_ic_pkg::data_t fc_wdata_i,
    input  soc_ic_pkg::be_t   fc_be_i,
    output logic              fc_gnt_o,
    output logic              fc_r_valid_o,
    output soc_ic_pkg::data_t fc_r_rdata_o,
    output logic              fc_r_opc_o,
    // uDMA channel
    input  logic              udma_req_i,
    input  soc_ic_pkg::addr_t udma_add_i,
    input  logic              udma_wen_i,
    input  soc_ic_pkg::data_t udma_wdata_i,
    input  soc_ic_pkg::be_t   udma_be_i,
    output logic              udma_gnt_o,
    output logic              udma_r_valid_o,
    output soc_ic_pkg::data_t udma_r_rdata_o,
    output logic              udma_r_opc_o
);
    import soc_ic_pkg::*;

    logic push;        // Arbiter to FIFO
    req_t push_data;
    logic fifo_full;
    logic fifo_empty;  // FIFO to memory
    logic pop;
    req_t fifo_head;

    // Producer, alias and decode
    tcdm_master_arbiter i_arbiter (
        .clk_i, .reset_i,
        .fc_req_i, .fc_wen_i, .fc_add_i, .fc_wdata_i, .fc_be_i, .fc_gnt_o,
        .udma_req_i, .udma_wen_i, .udma_add_i, .udma_wdata_i, .udma_be_i, .udma_gnt_o,
        .fifo_full_i (fifo_full),
        .push_o      (push),
        .push_data_o (push_data)
    );

    req_fifo i_req_fifo (
        .clk_i, .reset_i,
        .push_i      (push),
        .pop_i       (pop),
        .push_data_i (push_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .head_o      (fifo_head)
    );

    // Consumer, banks and response routing
    l2_memory i_l2_memory (
        .clk_i, .reset_i,
        .empty_i (fifo_empty),
        .head_i  (fifo_head),
        .pop_o   (pop),
        .fc_r_valid_o, .fc_r_opc_o, .fc_r_rdata_o,
        .udma_r_valid_o, .udma_r_opc_o, .udma_r_rdata_o
    );

endmodule

`default_nettype wire

// File: tests/soc_ic_assertions.sv
`default_nettype none

module soc_ic_assertions (
    input logic clk_i,
    input logic reset_i,
    input logic fc_req_i,
    input logic fc_gnt_i,
    input logic fc_r_valid_i,
    input logic udma_req_i,
    input logic udma_gnt_i,
    input logic udma_r_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;  // Failures so far, read by the testbench

    ////////////////////////////////////////
    // Grant rules
    ////////////////////////////////////////

    fc_gnt_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        fc_gnt_i |-> fc_req_i)
        else begin
            fail_cnt++;
            $error("fc_gnt_o high without fc_req_i");
        end

    udma_gnt_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        udma_gnt_i |-> udma_req_i)
        else begin
            fail_cnt++;
            $error("udma_gnt_o high without udma_req_i");
        end

    // One winner per cycle
    single_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
        !(fc_gnt_i && udma_gnt_i))
        else begin
            fail_cnt++;
            $error("fc_gnt_o and udma_gnt_o high together");
        end

    // Quiet response ports in the two cycles after reset
    no_rsp_after_reset: assert property (@(posedge clk_i)
        (!reset_i && ($past(reset_i) || $past(reset_i, 2))) |-> !(fc_r_valid_i || udma_r_valid_i))
        else begin
            fail_cnt++;
            $error("r_valid_o high right after reset");
        end

endmodule

bind soc_interconnect_top soc_ic_assertions assertions0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fc_req_i       (fc_req_i),
    .fc_gnt_i       (fc_gnt_o),
    .fc_r_valid_i   (fc_r_valid_o),
    .udma_req_i     (udma_req_i),
    .udma_gnt_i     (udma_gnt_o),
    .udma_r_valid_i (udma_r_valid_o)
);

`default_nettype wire

// File: tests/soc_ic_tb.sv
`default_nettype none

module soc_ic_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import soc_ic_pkg::*;

    localparam int         MAX_CASES  = 64;
    localparam logic [3:0] CODE_FC    = 4'h0;  // Master column of the case file
    localparam logic [3:0] CODE_UDMA  = 4'h1;
    localparam logic [3:0] CODE_FENCE = 4'hF;  // Drain both masters before going on

    logic  clk;
    logic  reset;
    logic  fc_req;
    logic  fc_wen;
    addr_t fc_add;
    data_t fc_wdata;
    be_t   fc_be;
    logic  fc_gnt;
    logic  fc_r_valid;
    data_t fc_r_rdata;
    logic  fc_r_opc;
    logic  udma_req;
    logic  udma_wen;
    addr_t udma_add;
    data_t udma_wdata;
    be_t   udma_be;
    logic  udma_gnt;
    logic  udma_r_valid;
    data_t udma_r_rdata;
    logic  udma_r_opc;

    // Case table
    logic [3:0] c_mst   [MAX_CASES];
    logic       c_wen   [MAX_CASES];
    addr_t      c_add   [MAX_CASES];
    data_t      c_wdata [MAX_CASES];
    be_t        c_be    [MAX_CASES];
    data_t      c_rdata [MAX_CASES];
    logic       c_opc   [MAX_CASES];
    int         c_gap   [MAX_CASES];  // Idle cycles after the request
    int         n_lines;
    int         n_access;              // Lines that are not fences

    logic [32:0] fc_exp_q [$];    // {opc, rdata} in issue order
    logic [32:0] udma_exp_q [$];
    logic [32:0] exp_word;

    int     err_value  = 0;  // Wrong rdata or opc
    int     err_proto  = 0;  // Response with nothing outstanding
    int     err_end    = 0;
    int     err_assert = 0;  // Bound checker
    int     fc_grants  = 0;
    int     udma_grants = 0;
    int     fc_rsp     = 0;
    int     udma_rsp   = 0;
    int     contention = 0;  // Cycles with both masters requesting
    int     cycles     = 0;
    int     cycle_limit;
    int     seg_start;
    integer seed;

    soc_interconnect_top dut0 (
        .clk_i          (clk),
        .reset_i        (reset),
        .fc_req_i       (fc_req),
        .fc_add_i       (fc_add),
        .fc_wen_i       (fc_wen),
        .fc_wdata_i     (fc_wdata),
        .fc_be_i        (fc_be),
        .fc_gnt_o       (fc_gnt),
        .fc_r_valid_o   (fc_r_valid),
        .fc_r_rdata_o   (fc_r_rdata),
        .fc_r_opc_o     (fc_r_opc),
        .udma_req_i     (udma_req),
        .udma_add_i     (udma_add),
        .udma_wen_i     (udma_wen),
        .udma_wdata_i   (udma_wdata),
        .udma_be_i      (udma_be),
        .udma_gnt_o     (udma_gnt),
        .udma_r_valid_o (udma_r_valid),
        .udma_r_rdata_o (udma_r_rdata),
        .udma_r_opc_o   (udma_r_opc)
    );

    always #2 clk = ~clk;  // 4 ns period

    ////////////////////////////////////////
    // Case file and request driving
    ////////////////////////////////////////

    task automatic load_cases();
        integer      fd;
        integer      n;
        string       line;
        logic [31:0] f_mst;
        logic [31:0] f_wen;
        logic [31:0] f_add;
        logic [31:0] f_wdata;
        logic [31:0] f_be;
        logic [31:0] f_rdata;
        logic [31:0] f_opc;
        n_lines  = 0;
        n_access = 0;
        fd = $fopen("tests/soc_ic_cases.txt", "r");
        if (fd == 0) begin
            err_end++;
            $display("ERROR: cannot open tests/soc_ic_cases.txt");
        end else begin
            while (!$feof(fd) && n_lines < MAX_CASES) begin
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f_mst, f_wen, f_add, f_wdata, f_be, f_rdata, f_opc);
                if (n == 7) begin                      // Comment and blank lines skipped
                    c_mst[n_lines]   = f_mst[3:0];
                    c_wen[n_lines]   = f_wen[0];
                    c_add[n_lines]   = f_add;
                    c_wdata[n_lines] = f_wdata;
                    c_be[n_lines]    = f_be[3:0];
                    c_rdata[n_lines] = f_rdata;
                    c_opc[n_lines]   = f_opc[0];
                    c_gap[n_lines]   = {$random(seed)} % 3;  // 0 to 2 idle cycles
                    if (f_mst[3:0] != CODE_FENCE) n_access++;
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_req(input int idx);
        if (c_mst[idx] == CODE_FC) begin
            fc_req   = 1'b1;
            fc_wen   = c_wen[idx];
            fc_add   = c_add[idx];
            fc_wdata = c_wdata[idx];
            fc_be    = c_be[idx];
        end else begin
            udma_req   = 1'b1;
            udma_wen   = c_wen[idx];
            udma_add   = c_add[idx];
            udma_wdata = c_wdata[idx];
            udma_be    = c_be[idx];
        end
    endtask

    // Request held until granted, then the gap
    task automatic issue_case(input int idx);
        logic granted;
        granted = 1'b0;
        drive_req(idx);
        while (!granted) begin
            #1;  // Mid low phase, grant settled
            if (c_mst[idx] == CODE_FC && fc_gnt) begin
                granted = 1'b1;
                fc_grants++;
                fc_exp_q.push_back({c_opc[idx], c_rdata[idx]});
            end else if (c_mst[idx] == CODE_UDMA && udma_gnt) begin
                granted = 1'b1;
                udma_grants++;
                udma_exp_q.push_back({c_opc[idx], c_rdata[idx]});
            end
            @(negedge clk);
        end
        if (c_mst[idx] == CODE_FC) fc_req = 1'b0;
        else udma_req = 1'b0;
        repeat (c_gap[idx]) @(negedge clk);
    endtask

    task automatic run_master(input logic [3:0] mst, input int first, input int last);
        for (int i = first; i < last; i++) begin
            if (c_mst[i] == mst) issue_case(i);  // File order per master
        end
    endtask

    task automatic wait_drain();
        @(posedge clk);
        while (fc_exp_q.size() != 0 || udma_exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
    endtask

    ////////////////////////////////////////
    // Response checking
    ////////////////////////////////////////

    task automatic check_rsp(input string port, input logic [32:0] exp,
                             input data_t rdata, input logic opc);
        assert (rdata === exp[31:0]) else begin
            err_value++;
            $display("FAIL t=%0t %s_r_rdata_o got %h expected %h", $time, port, rdata, exp[31:0]);
        end
        assert (opc === exp[32]) else begin
            err_value++;
            $display("FAIL t=%0t %s_r_opc_o got %b expected %b", $time, port, opc, exp[32]);
        end
    endtask

    // Outputs registered, stable at the falling edge
    always @(negedge clk) begin
        if (fc_r_valid) begin
            fc_rsp++;
            assert (fc_exp_q.size() > 0) else begin
                err_proto++;
                $display("ERROR: fc_r_valid_o at %0t with no request outstanding", $time);
            end
            if (fc_exp_q.size() > 0) begin
                exp_word = fc_exp_q.pop_front();
                check_rsp("fc", exp_word, fc_r_rdata, fc_r_opc);
            end
        end
        if (udma_r_valid) begin
            udma_rsp++;
            assert (udma_exp_q.size() > 0) else begin
                err_proto++;
                $display("ERROR: udma_r_valid_o at %0t with no request outstanding", $time);
            end
            if (udma_exp_q.size() > 0) begin
                exp_word = udma_exp_q.pop_front();
                check_rsp("udma", exp_word, udma_r_rdata, udma_r_opc);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (fc_req && udma_req) contention++;
        if (cycles >= cycle_limit) begin
            $display("ERROR: timeout after %0d cycles with responses outstanding", cycles);
            $display("errors: %0d value, %0d protocol", err_value, err_proto);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        fc_req     = 1'b0;
        fc_wen     = 1'b1;
        fc_add     = '0;
        fc_wdata   = '0;
        fc_be      = '0;
        udma_req   = 1'b0;
        udma_wen   = 1'b1;
        udma_add   = '0;
        udma_wdata = '0;
        udma_be    = '0;
        seed       = 32'h2d9c_70d7;
        load_cases();
        cycle_limit = 40 * n_access + 100;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        seg_start = 0;
        for (int i = 0; i <= n_lines; i++) begin
            if (i == n_lines || c_mst[i] == CODE_FENCE) begin
                fork                                  // Both masters at once
                    run_master(CODE_FC, seg_start, i);
                    run_master(CODE_UDMA, seg_start, i);
                join
                wait_drain();
                seg_start = i + 1;
            end
        end
        repeat (4) @(negedge clk);  // Catch stray responses
        assert (fc_rsp == fc_grants) else begin
            err_end++;
            $display("FAIL t=%0t fc_r_valid_o pulses got %0d expected %0d",
                     $time, fc_rsp, fc_grants);
        end
        assert (udma_rsp == udma_grants) else begin
            err_end++;
            $display("FAIL t=%0t udma_r_valid_o pulses got %0d expected %0d",
                     $time, udma_rsp, udma_grants);
        end
        assert (contention > 0) else begin
            err_end++;
            $display("ERROR: the two masters never requested in the same cycle");
        end
        assert (n_access > 0) else begin
            err_end++;
            $display("ERROR: no accesses were read from the case file");
        end
        err_assert = int'(dut0.assertions0.fail_cnt);
        $display("errors: %0d total, %0d value, %0d protocol, %0d end of run, %0d assertion",
                 err_value + err_proto + err_end + err_assert,
                 err_value, err_proto, err_end, err_assert);
        if (err_value + err_proto + err_end + err_assert == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/soc_ic_cases.txt
# mst(0 fc, 1 udma, F fence) wen(1 read, 0 write) addr wdata be exp_rdata exp_opc
# A fence line waits until both masters have every earlier response
0 0 1C000000 11223344 F 00000000 0
0 0 1C000000 AABBCCDD 5 00000000 0
0 1 1C000000 00000000 0 11BB33DD 0
1 0 1C0001FC 0BADF00D F 00000000 0
1 1 1C0001FC 00000000 0 0BADF00D 0
1 1 1C000004 00000000 0 00000000 0
F 0 00000000 00000000 0 00000000 0
0 0 1C010040 00000040 F 00000000 0
0 0 1C010044 00000044 F 00000000 0
0 0 1C010048 00000048 F 00000000 0
0 0 1C01004C 0000004C F 00000000 0
1 0 1C010100 DEADBEEF F 00000000 0
1 0 1C010104 CAFEF00D 3 00000000 0
1 1 1C010104 00000000 0 0000F00D 0
0 1 1C010040 00000000 0 00000040 0
0 1 1C010044 00000000 0 00000044 0
0 1 1C010048 00000000 0 00000048 0
0 1 1C01004C 00000000 0 0000004C 0
0 1 1C010050 00000000 0 00000000 0
F 0 00000000 00000000 0 00000000 0
0 0 00000010 5A5AA5A5 F 00000000 0
0 1 00000010 00000000 0 5A5AA5A5 0
1 1 00000010 00000000 0 BADCAB1E 1
F 0 00000000 00000000 0 00000000 0
1 1 1C000010 00000000 0 5A5AA5A5 0
1 0 1C000200 FFFFFFFF F 00000000 1
1 1 1C000000 00000000 0 11BB33DD 0
0 1 1C000200 00000000 0 BADCAB1E 1
0 0 1C010400 12345678 F 00000000 1
0 1 1C010000 00000000 0 00000000 0
1 1 1C010100 00000000 0 DEADBEEF 0
0 1 1C010044 00000000 0 00000044 0

// File: project.f
+incdir+hdl
hdl/soc_ic_pkg.sv
hdl/tcdm_master_arbiter.sv
hdl/req_fifo.sv
hdl/l2_memory.sv
hdl/soc_interconnect_top.sv
tests/soc_ic_assertions.sv
tests/soc_ic_tb.sv

// File: Makefile
# Verilator build and run of the interconnect testbench

TOP = soc_ic_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   this list"

obj_dir/V$(TOP): project.f $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
	verilator --binary --assert --timing --timescale 1ns/1ps -f project.f --top-module $(TOP) -o V$(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
